//--- include/csr_gen_cfg.svh
// CSR index generator configuration
// Widths and FIFO sizing shared by the package and the RTL blocks

`ifndef CSR_GEN_CFG_SVH
`define CSR_GEN_CFG_SVH

// ------------------------------------------------------------
// Field widths
// ------------------------------------------------------------
// Index, start, end, stride and data field
`define CSR_GEN_INDEX_W 16

// Array pointer and request offset
`define CSR_GEN_ADDR_W 32

// Shift amount applied to the index
`define CSR_GEN_SHIFT_W 3

// ------------------------------------------------------------
// Request FIFO sizing
// ------------------------------------------------------------
`define CSR_GEN_FIFO_DEPTH 16

// Leaves room for the requests still in the pipeline
`define CSR_GEN_PROG_THRESH 8

`endif

//--- design/csr_gen_pkg.sv
// CSR index generator types
// Sequencer states, request status and the captured configuration

`include "csr_gen_cfg.svh"

package csr_gen_pkg;

    // ------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        RESET       = 3'd0,
        IDLE        = 3'd1,
        SETUP_TRANS = 3'd2,
        SETUP       = 3'd3,
        START       = 3'd4,
        BUSY        = 3'd5,
        PAUSE       = 3'd6,
        DONE        = 3'd7
    } seq_state_e;

    // Carried with every request and set to LAST only on the final index
    typedef enum logic {
        RUNNING = 1'b0,
        LAST    = 1'b1
    } seq_status_e;

    // ------------------------------------------------------------
    // Configuration word
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`CSR_GEN_ADDR_W-1:0]  array_pointer;
        logic [`CSR_GEN_INDEX_W-1:0] index_start;
        logic [`CSR_GEN_INDEX_W-1:0] index_end;
        logic [`CSR_GEN_INDEX_W-1:0] stride;
        logic [`CSR_GEN_SHIFT_W-1:0] shift_amount;
        // Set for a left shift and clear for a right shift
        logic                        shift_left;
    } index_config_t;

endpackage

//--- design/csr_gen_config_regs.sv
// Configuration register block
// Registers the start pulse and holds the configuration word
// that steers the index sequencer

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module csr_gen_config_regs (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          start,
    input  logic                          cfg_valid,
    input  logic [`CSR_GEN_ADDR_W-1:0]    cfg_array_pointer,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_start,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_end,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_stride,
    input  logic [`CSR_GEN_SHIFT_W-1:0]   cfg_shift_amount,
    input  logic                          cfg_shift_left,
    input  logic                          capture,
    output logic                          start_seen,
    output csr_gen_pkg::index_config_t    index_config
);

    logic load_config;

    // ------------------------------------------------------------
    // Start pulse
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start_seen <= 1'b0;
        end else begin
            start_seen <= start;
        end
    end

    // ------------------------------------------------------------
    // Configuration word
    // ------------------------------------------------------------
    // Words outside the setup window are ignored
    assign load_config = cfg_valid & capture;

    always_ff @(posedge ap_clk) begin
        if (load_config) begin
            index_config.array_pointer <= cfg_array_pointer;
            index_config.index_start   <= cfg_index_start;
            index_config.index_end     <= cfg_index_end;
            index_config.stride        <= cfg_stride;
            index_config.shift_amount  <= cfg_shift_amount;
            index_config.shift_left    <= cfg_shift_left;
        end
    end

endmodule

//--- design/index_sequencer.sv
// Index sequencer
// FSM that requests the configuration, then walks the index range
// by the stride, one index per cycle, pausing on FIFO near-full

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module index_sequencer (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          start_seen,
    input  logic                          cfg_valid,
    input  csr_gen_pkg::index_config_t    index_config,
    input  logic                          near_full,
    output logic                          cfg_setup,
    output logic                          capture,
    output logic                          gen_valid,
    output logic [`CSR_GEN_INDEX_W-1:0]   gen_index,
    output logic                          gen_last,
    output logic                          done
);

    csr_gen_pkg::seq_state_e state;
    csr_gen_pkg::seq_state_e next_state;

    // One extra bit so count plus stride never wraps
    logic [`CSR_GEN_INDEX_W:0] count_q;
    logic [`CSR_GEN_INDEX_W:0] count_next;
    logic [`CSR_GEN_INDEX_W:0] index_end_ext;
    logic                      in_range;

    // Delays done until the builder pipeline has drained
    logic [1:0] done_dly;

    // ------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= csr_gen_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csr_gen_pkg::RESET: next_state = csr_gen_pkg::IDLE;
            csr_gen_pkg::IDLE: begin
                if (start_seen) next_state = csr_gen_pkg::SETUP_TRANS;
            end
            csr_gen_pkg::SETUP_TRANS: next_state = csr_gen_pkg::SETUP;
            csr_gen_pkg::SETUP: begin
                if (cfg_valid) next_state = csr_gen_pkg::START;
            end
            csr_gen_pkg::START: next_state = csr_gen_pkg::BUSY;
            csr_gen_pkg::BUSY: begin
                // Still issues this cycle when entering PAUSE
                if (!in_range) begin
                    next_state = csr_gen_pkg::DONE;
                end else if (near_full) begin
                    next_state = csr_gen_pkg::PAUSE;
                end
            end
            csr_gen_pkg::PAUSE: begin
                if (!near_full) next_state = csr_gen_pkg::BUSY;
            end
            csr_gen_pkg::DONE: begin
                // Restart from done
                if (start_seen) next_state = csr_gen_pkg::SETUP_TRANS;
            end
            default: next_state = csr_gen_pkg::IDLE;
        endcase
    end

    assign cfg_setup = (state == csr_gen_pkg::SETUP_TRANS);
    assign capture   = (state == csr_gen_pkg::SETUP);

    // ------------------------------------------------------------
    // Stride counter and end test
    // ------------------------------------------------------------
    assign index_end_ext = {1'b0, index_config.index_end};
    assign count_next    = count_q + {1'b0, index_config.stride};
    assign in_range      = (count_q < index_end_ext);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count_q <= '0;
        end else if (state == csr_gen_pkg::START) begin
            count_q <= {1'b0, index_config.index_start};
        end else if (gen_valid) begin
            count_q <= count_next;
        end
    end

    assign gen_valid = (state == csr_gen_pkg::BUSY) & in_range;
    assign gen_index = count_q[`CSR_GEN_INDEX_W-1:0];
    // Final index when the next step leaves the range
    assign gen_last  = gen_valid & (count_next >= index_end_ext);

    // ------------------------------------------------------------
    // Done level
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done_dly <= 2'b00;
        end else if (state == csr_gen_pkg::DONE) begin
            done_dly <= {done_dly[0], 1'b1};
        end else begin
            done_dly <= 2'b00;
        end
    end

    assign done = done_dly[1];

endmodule

//--- design/request_builder.sv
// Request builder
// Two-stage pipeline turning an index into a memory request with
// base, shifted offset, index data and sequence status

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module request_builder (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          gen_valid,
    input  logic [`CSR_GEN_INDEX_W-1:0]   gen_index,
    input  logic                          gen_last,
    input  csr_gen_pkg::index_config_t    index_config,
    output logic                          push,
    output logic [`CSR_GEN_ADDR_W-1:0]    entry_base,
    output logic [`CSR_GEN_ADDR_W-1:0]    entry_offset,
    output logic [`CSR_GEN_INDEX_W-1:0]   entry_index,
    output csr_gen_pkg::seq_status_e      entry_status
);

    logic [`CSR_GEN_ADDR_W-1:0]  index_ext;
    logic [`CSR_GEN_ADDR_W-1:0]  shifted;

    logic                        s1_valid;
    logic                        s1_last;
    logic [`CSR_GEN_INDEX_W-1:0] s1_index;
    logic [`CSR_GEN_ADDR_W-1:0]  s1_offset;

    // ------------------------------------------------------------
    // Stage 1 offset
    // ------------------------------------------------------------
    assign index_ext = {{(`CSR_GEN_ADDR_W-`CSR_GEN_INDEX_W){1'b0}}, gen_index};
    assign shifted   = index_config.shift_left ? (index_ext << index_config.shift_amount)
                                               : (index_ext >> index_config.shift_amount);

    always_ff @(posedge ap_clk) begin
        s1_last   <= gen_last;
        s1_index  <= gen_index;
        s1_offset <= shifted;
    end

    // ------------------------------------------------------------
    // Stage 2 base and status
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        entry_base   <= index_config.array_pointer;
        entry_offset <= s1_offset;
        entry_index  <= s1_index;
        entry_status <= s1_last ? csr_gen_pkg::LAST : csr_gen_pkg::RUNNING;
    end

    // Valid bits
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= gen_valid;
            push     <= s1_valid;
        end
    end

endmodule

//--- design/request_fifo.sv
// Request FIFO
// Synchronous circular buffer with an occupancy count, a near-full
// flag at the programmed threshold and a registered read port

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module request_fifo (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          push,
    input  logic [`CSR_GEN_ADDR_W-1:0]    entry_base,
    input  logic [`CSR_GEN_ADDR_W-1:0]    entry_offset,
    input  logic [`CSR_GEN_INDEX_W-1:0]   entry_index,
    input  csr_gen_pkg::seq_status_e      entry_status,
    input  logic                          pop,
    output logic                          near_full,
    output logic                          req_valid,
    output logic [`CSR_GEN_ADDR_W-1:0]    req_base,
    output logic [`CSR_GEN_ADDR_W-1:0]    req_offset,
    output logic [`CSR_GEN_INDEX_W-1:0]   req_index,
    output csr_gen_pkg::seq_status_e      req_status
);

    localparam int DEPTH = `CSR_GEN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [`CSR_GEN_ADDR_W-1:0]  mem_base   [DEPTH];
    logic [`CSR_GEN_ADDR_W-1:0]  mem_offset [DEPTH];
    logic [`CSR_GEN_INDEX_W-1:0] mem_index  [DEPTH];
    csr_gen_pkg::seq_status_e    mem_status [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign near_full = (count >= CNT_W'(`CSR_GEN_PROG_THRESH));

    // Pushes while full are dropped
    assign wr_en = push & ~full;
    assign rd_en = pop & ~empty;

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Storage and registered read
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_base[wr_ptr]   <= entry_base;
            mem_offset[wr_ptr] <= entry_offset;
            mem_index[wr_ptr]  <= entry_index;
            mem_status[wr_ptr] <= entry_status;
        end
        if (rd_en) begin
            req_base   <= mem_base[rd_ptr];
            req_offset <= mem_offset[rd_ptr];
            req_index  <= mem_index[rd_ptr];
            req_status <= mem_status[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= rd_en;
        end
    end

endmodule

//--- design/csr_index_generator.sv
// CSR edge-list index generator
// Requests a configuration on start, then queues one memory request
// per index of the strided range for a downstream reader

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module csr_index_generator (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          start,
    output logic                          cfg_setup,
    input  logic                          cfg_valid,
    input  logic [`CSR_GEN_ADDR_W-1:0]    cfg_array_pointer,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_start,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_end,
    input  logic [`CSR_GEN_INDEX_W-1:0]   cfg_stride,
    input  logic [`CSR_GEN_SHIFT_W-1:0]   cfg_shift_amount,
    input  logic                          cfg_shift_left,
    input  logic                          req_ready,
    output logic                          req_valid,
    output logic [`CSR_GEN_ADDR_W-1:0]    req_base,
    output logic [`CSR_GEN_ADDR_W-1:0]    req_offset,
    output logic [`CSR_GEN_INDEX_W-1:0]   req_index,
    output csr_gen_pkg::seq_status_e      req_status,
    output logic                          done
);

    logic                        start_seen;
    logic                        capture;
    csr_gen_pkg::index_config_t  index_config;

    logic                        gen_valid;
    logic [`CSR_GEN_INDEX_W-1:0] gen_index;
    logic                        gen_last;
    logic                        near_full;

    logic                        push;
    logic [`CSR_GEN_ADDR_W-1:0]  entry_base;
    logic [`CSR_GEN_ADDR_W-1:0]  entry_offset;
    logic [`CSR_GEN_INDEX_W-1:0] entry_index;
    csr_gen_pkg::seq_status_e    entry_status;

    csr_gen_config_regs u_config_regs (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .cfg_valid         (cfg_valid),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_index_start   (cfg_index_start),
        .cfg_index_end     (cfg_index_end),
        .cfg_stride        (cfg_stride),
        .cfg_shift_amount  (cfg_shift_amount),
        .cfg_shift_left    (cfg_shift_left),
        .capture           (capture),
        .start_seen        (start_seen),
        .index_config      (index_config)
    );

    index_sequencer u_index_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start_seen       (start_seen),
        .cfg_valid        (cfg_valid),
        .index_config     (index_config),
        .near_full        (near_full),
        .cfg_setup        (cfg_setup),
        .capture          (capture),
        .gen_valid        (gen_valid),
        .gen_index        (gen_index),
        .gen_last         (gen_last),
        .done             (done)
    );

    request_builder u_request_builder (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .gen_valid        (gen_valid),
        .gen_index        (gen_index),
        .gen_last         (gen_last),
        .index_config     (index_config),
        .push             (push),
        .entry_base       (entry_base),
        .entry_offset     (entry_offset),
        .entry_index      (entry_index),
        .entry_status     (entry_status)
    );

    request_fifo u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .entry_base       (entry_base),
        .entry_offset     (entry_offset),
        .entry_index      (entry_index),
        .entry_status     (entry_status),
        .pop              (req_ready),
        .near_full        (near_full),
        .req_valid        (req_valid),
        .req_base         (req_base),
        .req_offset       (req_offset),
        .req_index        (req_index),
        .req_status       (req_status)
    );

endmodule

//--- sim/csr_gen_asserts.sv
// CSR index generator assertions
// Bound to the top level; checks the setup pulse, reset values
// and that no request is pushed into a full FIFO

`timescale 1ns/1ps

module csr_gen_asserts (
    input logic ap_clk,
    input logic areset_generator,
    input logic cfg_setup,
    input logic done,
    input logic req_valid,
    input logic push,
    input logic fifo_full
);

    // Assertion failures so far
    int fail_count = 0;

    // ------------------------------------------------------------
    // Configuration request
    // ------------------------------------------------------------
    // Setup request is a single-cycle pulse
    cfg_setup_one_cycle: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        cfg_setup |=> !cfg_setup
    ) else begin
        $error("cfg_setup held for more than one cycle");
        fail_count++;
    end

    // Outputs come out of reset low
    outputs_low_after_reset: assert property (
        @(posedge ap_clk)
        areset_generator |=> (!cfg_setup && !done && !req_valid)
    ) else begin
        $error("cfg_setup, done or req_valid high after reset");
        fail_count++;
    end

    // ------------------------------------------------------------
    // Request FIFO
    // ------------------------------------------------------------
    // Threshold must leave room for requests still in flight
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push |-> !fifo_full
    ) else begin
        $error("request pushed into a full FIFO");
        fail_count++;
    end

endmodule

//--- sim/csr_index_generator_tb.sv
// CSR index generator testbench
// Directed sequences with a reference list built from the index
// rules, popping the request FIFO and checking every entry

`timescale 1ns/1ps

`include "csr_gen_cfg.svh"

module csr_index_generator_tb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                          ap_clk;
    logic                          areset_generator;
    logic                          start;
    logic                          cfg_setup;
    logic                          cfg_valid;
    logic [`CSR_GEN_ADDR_W-1:0]    cfg_array_pointer;
    logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_start;
    logic [`CSR_GEN_INDEX_W-1:0]   cfg_index_end;
    logic [`CSR_GEN_INDEX_W-1:0]   cfg_stride;
    logic [`CSR_GEN_SHIFT_W-1:0]   cfg_shift_amount;
    logic                          cfg_shift_left;
    logic                          req_ready;
    logic                          req_valid;
    logic [`CSR_GEN_ADDR_W-1:0]    req_base;
    logic [`CSR_GEN_ADDR_W-1:0]    req_offset;
    logic [`CSR_GEN_INDEX_W-1:0]   req_index;
    csr_gen_pkg::seq_status_e      req_status;
    logic                          done;

    int errors = 0;
    int cycle_count = 0;
    int got;
    logic [`CSR_GEN_ADDR_W-1:0]  cur_ptr;
    logic [`CSR_GEN_ADDR_W-1:0]  exp_offset [$];
    logic [`CSR_GEN_INDEX_W-1:0] exp_index [$];

    csr_index_generator uut (.*);

    bind csr_index_generator csr_gen_asserts u_asserts (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_setup        (cfg_setup),
        .done             (done),
        .req_valid        (req_valid),
        .push             (push),
        .fifo_full        (u_request_fifo.full)
    );

    always #5 ap_clk = ~ap_clk;

    // Run limit far above the summed test lengths
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_entry(input string what,
                               input logic [`CSR_GEN_ADDR_W-1:0] base,
                               input logic [`CSR_GEN_ADDR_W-1:0] want_base,
                               input logic [`CSR_GEN_ADDR_W-1:0] offset,
                               input logic [`CSR_GEN_ADDR_W-1:0] want_offset,
                               input logic [`CSR_GEN_INDEX_W-1:0] index,
                               input logic [`CSR_GEN_INDEX_W-1:0] want_index,
                               input csr_gen_pkg::seq_status_e status,
                               input csr_gen_pkg::seq_status_e want_status);
        if (base !== want_base || offset !== want_offset || index !== want_index ||
            status !== want_status) begin
            errors++;
            $display("mismatch @ %0t: %s got %h/%h/%0d/%s, expected %h/%h/%0d/%s",
                     $time, what, base, offset, index, status.name(),
                     want_base, want_offset, want_index, want_status.name());
        end
    endtask

    task automatic check_level(input string what, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("mismatch @ %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // ------------------------------------------------------------
    // Reference list and FIFO reader
    // ------------------------------------------------------------
    // Indices from start by stride while below end
    task automatic build_model(input int first, input int last, input int stride,
                               input int shamt, input bit left);
        logic [`CSR_GEN_ADDR_W-1:0] v;
        logic [`CSR_GEN_ADDR_W-1:0] scale;
        exp_offset.delete();
        exp_index.delete();
        scale = 1;
        repeat (shamt) begin
            scale = scale * 2;
        end
        for (int i = first; i < last; i += stride) begin
            v = i;
            exp_index.push_back(i[`CSR_GEN_INDEX_W-1:0]);
            // Left shift scales the index up, right shift divides it down
            exp_offset.push_back(left ? (v * scale) : (v / scale));
        end
    endtask

    function automatic logic next_pop(input bit random_gaps);
        if (random_gaps) begin
            return (($urandom % 3) != 0);
        end
        return 1'b1;
    endfunction

    // Samples the read port just after a rising edge
    task automatic collect_entry();
        csr_gen_pkg::seq_status_e want_status;
        if (req_valid) begin
            if (got < exp_index.size()) begin
                want_status = (got == exp_index.size() - 1) ? csr_gen_pkg::LAST
                                                            : csr_gen_pkg::RUNNING;
                check_entry("request entry", req_base, cur_ptr, req_offset, exp_offset[got],
                            req_index, exp_index[got], req_status, want_status);
            end else begin
                errors++;
                $display("mismatch @ %0t: unexpected entry with index %0d", $time, req_index);
            end
            got++;
        end
    endtask

    // ------------------------------------------------------------
    // Sequence driver
    // ------------------------------------------------------------
    task automatic run_sequence(input logic [`CSR_GEN_ADDR_W-1:0] ptr,
                                input int first, input int last, input int stride,
                                input int shamt, input bit left,
                                input int stall_cycles, input bit random_gaps);
        int n_wait;
        int guard;
        build_model(first, last, stride, shamt, left);
        cur_ptr = ptr;
        got = 0;
        @(posedge ap_clk);
        start <= 1'b1;
        n_wait = 0;
        do begin
            @(posedge ap_clk);
            start <= 1'b0;
            n_wait++;
        end while (!cfg_setup);
        // Start is sampled on the first edge and setup follows two cycles later
        check_level("edges from start to cfg_setup", n_wait, 3);
        cfg_valid         <= 1'b1;
        cfg_array_pointer <= ptr;
        cfg_index_start   <= first[`CSR_GEN_INDEX_W-1:0];
        cfg_index_end     <= last[`CSR_GEN_INDEX_W-1:0];
        cfg_stride        <= stride[`CSR_GEN_INDEX_W-1:0];
        cfg_shift_amount  <= shamt[`CSR_GEN_SHIFT_W-1:0];
        cfg_shift_left    <= left;
        @(posedge ap_clk);
        cfg_valid <= 1'b0;
        @(posedge ap_clk);
        check_level("done after new start", int'(done), 0);
        repeat (stall_cycles) begin
            @(posedge ap_clk);
            collect_entry();
        end
        // More entries than the FIFO holds so the generator must be paused
        if (stall_cycles > 0) check_level("done while reader stalled", int'(done), 0);
        while (!done) begin
            @(posedge ap_clk);
            collect_entry();
            req_ready <= next_pop(random_gaps);
        end
        guard = 0;
        while (got < exp_index.size() && guard < 200) begin
            @(posedge ap_clk);
            collect_entry();
            req_ready <= next_pop(random_gaps);
            guard++;
        end
        // A few extra strobes must find the FIFO empty
        for (int k = 0; k < 6; k++) begin
            @(posedge ap_clk);
            collect_entry();
            req_ready <= (k < 3);
        end
        check_level("entry count", got, exp_index.size());
        check_level("done held at end", int'(done), 1);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic basic_sequence();
        $display("running basic sequence");
        run_sequence(32'h1000_0000, 3, 10, 1, 2, 1'b1, 0, 1'b0);
    endtask

    task automatic stride_right_shift();
        $display("running stride with right shift");
        run_sequence(32'h2000_0040, 0, 40, 5, 1, 1'b0, 0, 1'b0);
    endtask

    task automatic back_pressure();
        $display("running back-pressure");
        run_sequence(32'h3000_0000, 100, 130, 1, 3, 1'b1, 40, 1'b1);
    endtask

    task automatic empty_range();
        $display("running empty range");
        run_sequence(32'h4000_0000, 25, 25, 1, 0, 1'b1, 0, 1'b0);
    endtask

    task automatic restart_from_done();
        $display("running restart from done");
        run_sequence(32'h5000_1000, 7, 19, 3, 1, 1'b1, 0, 1'b0);
        run_sequence(32'h6000_2000, 2, 50, 8, 2, 1'b0, 0, 1'b1);
    endtask

    initial begin
        void'($urandom(82741));
        ap_clk            = 1'b0;
        areset_generator  = 1'b1;
        start             = 1'b0;
        cfg_valid         = 1'b0;
        cfg_array_pointer = '0;
        cfg_index_start   = '0;
        cfg_index_end     = '0;
        cfg_stride        = '0;
        cfg_shift_amount  = '0;
        cfg_shift_left    = 1'b0;
        req_ready         = 1'b0;
        repeat (5) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        check_level("done after reset", int'(done), 0);
        check_level("req_valid after reset", int'(req_valid), 0);

        basic_sequence();
        stride_right_shift();
        back_pressure();
        empty_range();
        restart_from_done();

        errors += uut.u_asserts.fail_count;
        $display("closing report: %0d errors in %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
design/csr_gen_pkg.sv
design/csr_gen_config_regs.sv
design/index_sequencer.sv
design/request_builder.sv
design/request_fifo.sv
design/csr_index_generator.sv
sim/csr_gen_asserts.sv
sim/csr_index_generator_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR index generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module csr_index_generator_tb \
    -Mdir obj_dir -o sim_tb

status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" <<< "$output"; then
    exit 0
fi
exit 1
